/* filelist.f */
+incdir+common
common/mcu_pkg.sv
hw/spi_slave.sv
mcu_cmd/mcu_cmd.sv
hw/mem_port.sv
hw/clk_test.sv
hw/mcu_if_top.sv
testbench/tb_clk_gen.sv
testbench/mcu_if_chk.sv
testbench/mcu_if_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the mcu interface testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module mcu_if_tb \
  -f filelist.f \
  -o Vmcu_if_tb

./obj_dir/Vmcu_if_tb

/* testbench/mcu_if_tb.sv */
`timescale 1ns/1ps
`include "mcu_params.svh"

module mcu_if_tb;

  // sck half period in clk cycles
  localparam int HALF_CLKS    = 16;
  localparam int SYS_HALF     = 7;
  // sum of all transfer lengths below
  localparam int TOTAL_BYTES  = 263;
  localparam int TIMEOUT_CLKS = TOTAL_BYTES * 8 * 32 * 3 / 2;

  logic                   clk;
  logic                   rst;
  logic                   sck;
  logic                   cs_n;
  logic                   mosi;
  logic                   snes_sysclk = 1'b0;
  logic                   miso;
  logic [`MCU_ADDR_W-1:0] rom_mask;
  logic [`MCU_ADDR_W-1:0] saveram_mask;
  logic [7:0]             feature_bits;

  int                     sys_div = 0;
  int                     cycle_cnt = 0;
  integer                 seed = 32'h1398;

  logic [7:0]             tx_buf [$];
  logic [7:0]             rx_buf [$];
  string                  name_q [$];
  logic [31:0]            got_q [$];
  logic [31:0]            exp_q [$];

  logic [7:0]             model_mem [1 << `MEM_IDX_W];
  logic [`MCU_ADDR_W-1:0] model_rom_mask = '0;
  logic [`MCU_ADDR_W-1:0] model_sr_mask = '0;

  tb_clk_gen u_tb_clk_gen (
    .clk (clk),
    .rst (rst)
  );

  mcu_if_top u_mcu_if_top (
    .clk          (clk),
    .rst          (rst),
    .sck          (sck),
    .cs_n         (cs_n),
    .mosi         (mosi),
    .snes_sysclk  (snes_sysclk),
    .miso         (miso),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask),
    .feature_bits (feature_bits)
  );

  ////////////////////////////////////////
  // memory model

  // region bit over the masked low address bits
  function automatic logic [`MEM_IDX_W-1:0] mem_index(input logic region,
                                                      input logic [`MCU_ADDR_W-1:0] addr);
    logic [`MCU_ADDR_W-1:0] mask;
    mask = region ? model_sr_mask : model_rom_mask;
    return {region, addr[`MEM_IDX_W-2:0] & mask[`MEM_IDX_W-2:0]};
  endfunction

  function automatic logic [7:0] expected_byte(input logic region,
                                               input logic [`MCU_ADDR_W-1:0] addr);
    return model_mem[mem_index(region, addr)];
  endfunction

  ////////////////////////////////////////
  // checking

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
      $display("sim failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic post_check(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    name_q.push_back(name);
    got_q.push_back(got);
    exp_q.push_back(exp);
  endtask

  // results compared in the order they were queued
  always @(posedge clk) begin
    if (exp_q.size() != 0) begin
      check_value(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CLKS) begin
      $display("timeout: run went past %0d clock cycles", TIMEOUT_CLKS);
      $display("sim failed");
      $fatal(1, "timeout");
    end
  end

  // snes clock with a period of 14 clk cycles
  always @(posedge clk) begin
    if (sys_div == SYS_HALF - 1) begin
      sys_div     <= 0;
      snes_sysclk <= ~snes_sysclk;
    end else begin
      sys_div <= sys_div + 1;
    end
  end

  ////////////////////////////////////////
  // spi master in mode 0

  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
  endtask

  // sends tx_buf and collects the miso bytes in rx_buf
  task automatic spi_xfer();
    int         i;
    int         b;
    logic [7:0] cur;
    logic [7:0] rx;
    rx_buf.delete();
    rx = '0;
    cs_n <= 1'b0;
    for (i = 0; i < tx_buf.size(); i++) begin
      cur = tx_buf[i];
      for (b = 7; b >= 0; b--) begin
        mosi <= cur[b];
        wait_clks(HALF_CLKS);
        // miso sampled at the end of the low phase
        rx[b] = miso;
        sck <= 1'b1;
        wait_clks(HALF_CLKS);
        sck <= 1'b0;
      end
      rx_buf.push_back(rx);
    end
    wait_clks(HALF_CLKS);
    cs_n <= 1'b1;
    wait_clks(2 * HALF_CLKS);
  endtask

  task automatic set_addr(input logic [`MCU_ADDR_W-1:0] addr);
    tx_buf.delete();
    tx_buf.push_back(8'h00);
    tx_buf.push_back(addr[23:16]);
    tx_buf.push_back(addr[15:8]);
    tx_buf.push_back(addr[7:0]);
    spi_xfer();
  endtask

  task automatic load_mask(input logic region, input logic [`MCU_ADDR_W-1:0] mask);
    tx_buf.delete();
    tx_buf.push_back(region ? 8'h20 : 8'h10);
    tx_buf.push_back(mask[23:16]);
    tx_buf.push_back(mask[15:8]);
    tx_buf.push_back(mask[7:0]);
    spi_xfer();
    if (region) begin
      model_sr_mask = mask;
      post_check("saveram_mask", 32'(saveram_mask), 32'(mask));
    end else begin
      model_rom_mask = mask;
      post_check("rom_mask", 32'(rom_mask), 32'(mask));
    end
  endtask

  task automatic write_stream(input logic region, input logic [`MCU_ADDR_W-1:0] addr,
                              input int n);
    int         k;
    logic [7:0] d;
    set_addr(addr);
    tx_buf.delete();
    tx_buf.push_back({4'h9, region, 3'b000});
    for (k = 0; k < n; k++) begin
      d = 8'($random(seed));
      tx_buf.push_back(d);
      // later writes to an aliased index win
      model_mem[mem_index(region, addr + `MCU_ADDR_W'(k))] = d;
    end
    spi_xfer();
  endtask

  task automatic read_stream(input logic region, input logic [`MCU_ADDR_W-1:0] addr,
                             input int n);
    int k;
    set_addr(addr);
    tx_buf.delete();
    tx_buf.push_back({4'h8, region, 3'b000});
    for (k = 0; k < n; k++) begin
      tx_buf.push_back(8'h00);
    end
    spi_xfer();
    // memory at addr+k is the reply in byte k+2
    for (k = 0; k < n; k++) begin
      post_check($sformatf("miso byte %0d", k + 2), 32'(rx_buf[k + 1]),
                 32'(expected_byte(region, addr + `MCU_ADDR_W'(k))));
    end
  endtask

  ////////////////////////////////////////
  // test sequence
  initial begin
    logic [7:0]             feat;
    logic [`MCU_ADDR_W-1:0] base;
    logic [31:0]            freq_got;
    logic [31:0]            freq_exp;
    int                     k;

    sck  <= 1'b0;
    cs_n <= 1'b1;
    mosi <= 1'b0;
    while (rst !== 1'b0) @(posedge clk);
    wait_clks(4);

    // magic query then echo
    tx_buf.delete();
    tx_buf.push_back(8'hF0);
    tx_buf.push_back(8'h00);
    spi_xfer();
    post_check("miso byte 2", 32'(rx_buf[1]), 32'h0000_00A5);

    tx_buf.delete();
    tx_buf.push_back(8'hFF);
    for (k = 0; k < 4; k++) begin
      tx_buf.push_back(8'($random(seed)));
    end
    spi_xfer();
    for (k = 1; k < 4; k++) begin
      post_check($sformatf("miso byte %0d", k + 2), 32'(rx_buf[k + 1]), 32'(tx_buf[k]));
    end

    // feature bits and both masks at the ports
    feat = 8'($random(seed));
    tx_buf.delete();
    tx_buf.push_back(8'hED);
    tx_buf.push_back(feat);
    spi_xfer();
    post_check("feature_bits", 32'(feature_bits), 32'(feat));
    load_mask(1'b0, 24'($random(seed)));
    load_mask(1'b1, 24'($random(seed)));

    // both regions with full masks
    load_mask(1'b0, 24'hFF_FFFF);
    load_mask(1'b1, 24'hFF_FFFF);
    base = 24'($random(seed));
    write_stream(1'b0, base, 16);
    write_stream(1'b1, base, 16);
    read_stream(1'b0, base, 16);
    read_stream(1'b1, base, 16);

    // narrow rom mask gives eight aliased slots
    load_mask(1'b0, 24'h00_0007);
    base = 24'($random(seed));
    write_stream(1'b0, base, 20);
    read_stream(1'b0, base, 8);

    // long stream through the request queue
    base = 24'($random(seed));
    write_stream(1'b1, base, 48);
    read_stream(1'b1, base, 48);

    // frequency comes msb first in bytes 3 to 6
    tx_buf.delete();
    tx_buf.push_back(8'hFE);
    for (k = 0; k < 5; k++) begin
      tx_buf.push_back(8'h00);
    end
    spi_xfer();
    freq_got = {rx_buf[2], rx_buf[3], rx_buf[4], rx_buf[5]};
    freq_exp = 32'(`FREQ_WIN / (2 * SYS_HALF));
    // one edge of slack at the window borders
    if (freq_got + 32'd1 < freq_exp || freq_got > freq_exp + 32'd1) begin
      post_check("snes_sysclk_freq", freq_got, freq_exp);
    end

    while (exp_q.size() != 0) @(posedge clk);
    // one more edge so the last compare has run
    @(posedge clk);
    $display("sim passed");
    $finish;
  end

endmodule

/* testbench/mcu_if_chk.sv */
`timescale 1ns/1ps
`include "mcu_params.svh"

module mcu_if_chk (
  input logic                                clk,
  input logic                                rst,
  input mcu_pkg::mem_req_t                   mem_req,
  input mcu_pkg::mem_rsp_t                   mem_rsp,
  input logic                                credit,
  input logic [$clog2(`MEM_CREDITS + 1)-1:0] credits,
  input logic [7:0]                          tx_byte,
  input logic [7:0]                          feature_bits,
  input logic [`MCU_ADDR_W-1:0]              rom_mask,
  input logic [`MCU_ADDR_W-1:0]              saveram_mask
);

  // requests sent but not yet retired by the port
  logic [3:0] outstanding;

  always_ff @(posedge clk) begin
    if (rst) begin
      outstanding <= '0;
    end else begin
      outstanding <= outstanding + 4'(mem_req.valid) - 4'(credit);
    end
  end

  ////////////////////////////////////////
  a_req_credit: assert property (@(posedge clk) disable iff (rst)
    mem_req.valid |-> outstanding < 4'(`MEM_CREDITS) + 4'(credit))
    else $error("memory request sent with no credit left");

  a_credit_max: assert property (@(posedge clk) disable iff (rst)
    credits <= `MEM_CREDITS)
    else $error("credit count above queue depth");

  a_queue_bound: assert property (@(posedge clk) disable iff (rst)
    outstanding <= `MEM_CREDITS)
    else $error("more requests outstanding than queue entries");

  a_idle_reset: assert property (@(posedge clk)
    $fell(rst) |-> (!mem_req.valid && !credit && !mem_rsp.valid &&
                    credits == `MEM_CREDITS && tx_byte == '0 &&
                    feature_bits == '0 && rom_mask == '0 && saveram_mask == '0))
    else $error("decoder not idle after reset");

endmodule

bind mcu_cmd mcu_if_chk u_mcu_if_chk (
  .clk          (clk),
  .rst          (rst),
  .mem_req      (mem_req),
  .mem_rsp      (mem_rsp),
  .credit       (credit),
  .credits      (credits),
  .tx_byte      (tx_byte),
  .feature_bits (feature_bits),
  .rom_mask     (rom_mask),
  .saveram_mask (saveram_mask)
);

/* testbench/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // reset held for 16 rising edges
  initial begin
    rst <= 1'b1;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

/* hw/mcu_if_top.sv */
`timescale 1ns/1ps
`include "mcu_params.svh"

module mcu_if_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   sck,
  input  logic                   cs_n,
  input  logic                   mosi,
  input  logic                   snes_sysclk,
  output logic                   miso,
  output logic [`MCU_ADDR_W-1:0] rom_mask,
  output logic [`MCU_ADDR_W-1:0] saveram_mask,
  output logic [7:0]             feature_bits
);

  mcu_pkg::spi_byte_t spi_ev;
  mcu_pkg::mem_req_t  mem_req;
  mcu_pkg::mem_rsp_t  mem_rsp;
  logic [7:0]         tx_byte;
  logic               credit;
  logic [`FREQ_W-1:0] snes_sysclk_freq;

  spi_slave u_spi_slave (
    .clk     (clk),
    .rst     (rst),
    .sck     (sck),
    .cs_n    (cs_n),
    .mosi    (mosi),
    .tx_byte (tx_byte),
    .miso    (miso),
    .spi_ev  (spi_ev)
  );

  mcu_cmd u_mcu_cmd (
    .clk              (clk),
    .rst              (rst),
    .spi_ev           (spi_ev),
    .credit           (credit),
    .mem_rsp          (mem_rsp),
    .snes_sysclk_freq (snes_sysclk_freq),
    .tx_byte          (tx_byte),
    .mem_req          (mem_req),
    .rom_mask         (rom_mask),
    .saveram_mask     (saveram_mask),
    .feature_bits     (feature_bits)
  );

  // masks feed the port directly
  mem_port u_mem_port (
    .clk          (clk),
    .rst          (rst),
    .mem_req      (mem_req),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask),
    .credit       (credit),
    .mem_rsp      (mem_rsp)
  );

  clk_test u_clk_test (
    .clk              (clk),
    .rst              (rst),
    .sysclk           (snes_sysclk),
    .snes_sysclk_freq (snes_sysclk_freq)
  );

endmodule

/* hw/clk_test.sv */
`timescale 1ns/1ps
`include "mcu_params.svh"

module clk_test (
  input  logic               clk,
  input  logic               rst,
  input  logic               sysclk,
  output logic [`FREQ_W-1:0] snes_sysclk_freq
);

  localparam int WIN_W = $clog2(`FREQ_WIN);

  logic [2:0]         sys_sync;
  logic               sys_rise;
  logic [WIN_W-1:0]   win_cnt;
  logic [`FREQ_W-1:0] edge_cnt;

  assign sys_rise = sys_sync[1] & ~sys_sync[2];

  always_ff @(posedge clk) begin
    if (rst) begin
      sys_sync         <= '0;
      win_cnt          <= '0;
      edge_cnt         <= '0;
      snes_sysclk_freq <= '0;
    end else begin
      sys_sync <= {sys_sync[1:0], sysclk};
      if (win_cnt == WIN_W'(`FREQ_WIN - 1)) begin
        // window done, edge on the last cycle still counts
        win_cnt          <= '0;
        edge_cnt         <= '0;
        snes_sysclk_freq <= edge_cnt + `FREQ_W'(sys_rise);
      end else begin
        win_cnt  <= win_cnt + WIN_W'(1);
        edge_cnt <= edge_cnt + `FREQ_W'(sys_rise);
      end
    end
  end

endmodule

/* hw/mem_port.sv */
`timescale 1ns/1ps
`include "mcu_params.svh"

module mem_port (
  input  logic                   clk,
  input  logic                   rst,
  input  mcu_pkg::mem_req_t      mem_req,
  input  logic [`MCU_ADDR_W-1:0] rom_mask,
  input  logic [`MCU_ADDR_W-1:0] saveram_mask,
  output logic                   credit,
  output mcu_pkg::mem_rsp_t      mem_rsp
);

  localparam int DEPTH = `MEM_CREDITS;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int LOW_W = `MEM_IDX_W - 1;

  mcu_pkg::mem_req_t      fifo [DEPTH];
  mcu_pkg::mem_req_t      head;
  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;
  logic [CNT_W-1:0]       count;
  logic                   pop;
  logic [`MCU_ADDR_W-1:0] mask;
  logic                   s1_valid;
  logic                   s1_write;
  logic [`MEM_IDX_W-1:0]  s1_idx;
  logic [7:0]             s1_data;
  logic                   rsp_valid;
  logic [7:0]             rsp_data;
  logic [7:0]             mem [1 << `MEM_IDX_W];

  ////////////////////////////////////////
  // request queue
  assign pop  = (count != '0);
  assign head = fifo[rd_ptr];
  assign mask = (head.region == mcu_pkg::REG_SRAM) ? saveram_mask : rom_mask;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (mem_req.valid) wr_ptr <= wr_ptr + PTR_W'(1);
      if (pop) rd_ptr <= rd_ptr + PTR_W'(1);
      count <= count + CNT_W'(mem_req.valid) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (mem_req.valid) fifo[wr_ptr] <= mem_req;
  end

  ////////////////////////////////////////
  // stage 1, region mask
  always_ff @(posedge clk) begin
    if (rst) s1_valid <= 1'b0;
    else s1_valid <= pop;
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      s1_write <= head.write;
      s1_idx   <= {head.region, head.addr[LOW_W-1:0] & mask[LOW_W-1:0]};
      s1_data  <= head.data;
    end
  end

  // stage 2, array access and retire
  always_ff @(posedge clk) begin
    if (rst) begin
      credit    <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      credit    <= s1_valid;
      rsp_valid <= s1_valid & ~s1_write;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      if (s1_write) mem[s1_idx] <= s1_data;
      rsp_data <= mem[s1_idx];
    end
  end

  assign mem_rsp = '{valid: rsp_valid, data: rsp_data};

endmodule

/* mcu_cmd/mcu_cmd.sv */
`timescale 1ns/1ps
`include "mcu_params.svh"

module mcu_cmd (
  input  logic                   clk,
  input  logic                   rst,
  input  mcu_pkg::spi_byte_t     spi_ev,
  input  logic                   credit,
  input  mcu_pkg::mem_rsp_t      mem_rsp,
  input  logic [`FREQ_W-1:0]     snes_sysclk_freq,
  output logic [7:0]             tx_byte,
  output mcu_pkg::mem_req_t      mem_req,
  output logic [`MCU_ADDR_W-1:0] rom_mask,
  output logic [`MCU_ADDR_W-1:0] saveram_mask,
  output logic [7:0]             feature_bits
);

  localparam int CRED_W = $clog2(`MEM_CREDITS + 1);

  mcu_pkg::mcu_op_e       op;
  mcu_pkg::mcu_op_e       cur_op;
  mcu_pkg::mem_region_e   region;
  mcu_pkg::mem_region_e   cur_region;
  logic                   ev_any;
  logic [`MCU_ADDR_W-1:0] addr;
  logic [CRED_W-1:0]      credits;
  logic [CRED_W-1:0]      in_flight;
  logic [`FREQ_W-1:0]     freq_buf;
  mcu_pkg::mem_req_t      want_req;
  mcu_pkg::mem_req_t      pend;
  mcu_pkg::mem_req_t      next_req;
  logic                   issue;

  function automatic mcu_pkg::mcu_op_e decode(input logic [7:0] cmd);
    mcu_pkg::mcu_op_e res;
    case (cmd[7:4])
      4'h0: res = mcu_pkg::OP_SETADDR;
      4'h1: res = mcu_pkg::OP_ROMMASK;
      4'h2: res = mcu_pkg::OP_SRMASK;
      4'h8: res = mcu_pkg::OP_READ;
      4'h9: res = mcu_pkg::OP_WRITE;
      default: begin
        case (cmd)
          8'hED: res = mcu_pkg::OP_FEAT;
          8'hF0: res = mcu_pkg::OP_MAGIC;
          8'hFE: res = mcu_pkg::OP_FREQ;
          8'hFF: res = mcu_pkg::OP_ECHO;
          default: res = mcu_pkg::OP_NONE;
        endcase
      end
    endcase
    return res;
  endfunction

  // byte 1 decodes on the fly, later bytes use the held op
  assign ev_any     = spi_ev.cmd_ready | spi_ev.param_ready;
  assign cur_op     = spi_ev.cmd_ready ? decode(spi_ev.data) : op;
  assign cur_region = spi_ev.cmd_ready ? mcu_pkg::mem_region_e'(spi_ev.data[3]) : region;
  assign in_flight  = CRED_W'(`MEM_CREDITS) - credits;

  ////////////////////////////////////////
  // memory requests under credits
  always_comb begin
    want_req        = '0;
    want_req.valid  = ev_any && (cur_op == mcu_pkg::OP_READ ||
                      (cur_op == mcu_pkg::OP_WRITE && spi_ev.param_ready));
    want_req.write  = (cur_op == mcu_pkg::OP_WRITE);
    want_req.region = cur_region;
    want_req.data   = spi_ev.data;
  end

  assign next_req = pend.valid ? pend : want_req;
  assign issue    = next_req.valid && (credits != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      op      <= mcu_pkg::OP_NONE;
      region  <= mcu_pkg::REG_ROM;
      credits <= CRED_W'(`MEM_CREDITS);
      pend    <= '0;
      mem_req <= '0;
    end else begin
      credits <= credits + CRED_W'(credit) - CRED_W'(issue);
      if (spi_ev.cmd_ready) begin
        op     <= cur_op;
        region <= cur_region;
      end
      // spi byte spacing leaves at most one access waiting
      if (pend.valid ? issue : (want_req.valid && !issue)) begin
        pend <= want_req;
      end
      mem_req.valid <= issue;
      if (issue) begin
        mem_req.write  <= next_req.write;
        mem_req.region <= next_req.region;
        mem_req.data   <= next_req.data;
        // requests in flight have not bumped addr yet
        mem_req.addr   <= addr + `MCU_ADDR_W'(in_flight);
      end
    end
  end

  ////////////////////////////////////////
  // address, masks, feature bits
  always_ff @(posedge clk) begin
    if (rst) begin
      addr         <= '0;
      rom_mask     <= '0;
      saveram_mask <= '0;
      feature_bits <= '0;
    end else begin
      if (spi_ev.param_ready) begin
        case (op)
          mcu_pkg::OP_SETADDR: begin
            case (spi_ev.byte_cnt)
              32'd2: addr <= {spi_ev.data, 16'h0000};
              32'd3: addr[15:8] <= spi_ev.data;
              32'd4: addr[7:0] <= spi_ev.data;
              default: ;
            endcase
          end
          mcu_pkg::OP_ROMMASK: begin
            case (spi_ev.byte_cnt)
              32'd2: rom_mask[23:16] <= spi_ev.data;
              32'd3: rom_mask[15:8] <= spi_ev.data;
              32'd4: rom_mask[7:0] <= spi_ev.data;
              default: ;
            endcase
          end
          mcu_pkg::OP_SRMASK: begin
            case (spi_ev.byte_cnt)
              32'd2: saveram_mask[23:16] <= spi_ev.data;
              32'd3: saveram_mask[15:8] <= spi_ev.data;
              32'd4: saveram_mask[7:0] <= spi_ev.data;
              default: ;
            endcase
          end
          mcu_pkg::OP_FEAT: feature_bits <= spi_ev.data;
          default: ;
        endcase
      end
      // writes advance on retire, reads on data return
      if ((op == mcu_pkg::OP_WRITE && credit) ||
          (op == mcu_pkg::OP_READ && mem_rsp.valid)) begin
        addr <= addr + `MCU_ADDR_W'(1);
      end
    end
  end

  ////////////////////////////////////////
  // reply byte
  always_ff @(posedge clk) begin
    if (rst) begin
      tx_byte <= '0;
    end else if (spi_ev.cmd_ready) begin
      tx_byte <= (cur_op == mcu_pkg::OP_MAGIC) ? 8'hA5 : 8'h00;
    end else if (spi_ev.param_ready) begin
      case (op)
        mcu_pkg::OP_ECHO: tx_byte <= spi_ev.data;
        mcu_pkg::OP_FREQ: begin
          case (spi_ev.byte_cnt)
            32'd2: tx_byte <= freq_buf[31:24];
            32'd3: tx_byte <= freq_buf[23:16];
            32'd4: tx_byte <= freq_buf[15:8];
            32'd5: tx_byte <= freq_buf[7:0];
            default: tx_byte <= 8'h00;
          endcase
        end
        default: ;
      endcase
    end else if (op == mcu_pkg::OP_READ && mem_rsp.valid) begin
      tx_byte <= mem_rsp.data;
    end
  end

  // snapshot so all four bytes come from one window
  always_ff @(posedge clk) begin
    if (spi_ev.cmd_ready && cur_op == mcu_pkg::OP_FREQ) begin
      freq_buf <= snes_sysclk_freq;
    end
  end

endmodule

/* hw/spi_slave.sv */
`timescale 1ns/1ps

module spi_slave (
  input  logic               clk,
  input  logic               rst,
  input  logic               sck,
  input  logic               cs_n,
  input  logic               mosi,
  input  logic [7:0]         tx_byte,
  output logic               miso,
  output mcu_pkg::spi_byte_t spi_ev
);

  logic [2:0]  sck_sync;
  logic [1:0]  cs_sync;
  logic [1:0]  mosi_sync;
  logic        sck_rise;
  logic        sck_fall;
  logic        active;
  logic [2:0]  bit_cnt;
  logic [31:0] byte_cnt;
  logic [6:0]  rx_sr;
  logic [7:0]  tx_sr;

  // two flops, third one for edge detect
  always_ff @(posedge clk) begin
    if (rst) begin
      sck_sync  <= '0;
      cs_sync   <= '1;
      mosi_sync <= '0;
    end else begin
      sck_sync  <= {sck_sync[1:0], sck};
      cs_sync   <= {cs_sync[0], cs_n};
      mosi_sync <= {mosi_sync[0], mosi};
    end
  end

  assign sck_rise = sck_sync[1] & ~sck_sync[2];
  assign sck_fall = sck_sync[2] & ~sck_sync[1];
  assign active   = ~cs_sync[1];

  always_ff @(posedge clk) begin
    if (active && sck_rise) begin
      rx_sr <= {rx_sr[5:0], mosi_sync[1]};
    end
  end

  ////////////////////////////////////////
  // bit/byte counting, byte events
  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt  <= '0;
      byte_cnt <= '0;
      spi_ev   <= '0;
    end else begin
      spi_ev.cmd_ready   <= 1'b0;
      spi_ev.param_ready <= 1'b0;
      if (!active) begin
        bit_cnt  <= '0;
        byte_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7) begin
          byte_cnt           <= byte_cnt + 32'd1;
          spi_ev.cmd_ready   <= (byte_cnt == 32'd0);
          spi_ev.param_ready <= (byte_cnt != 32'd0);
          spi_ev.data        <= {rx_sr, mosi_sync[1]};
          spi_ev.byte_cnt    <= byte_cnt + 32'd1;
        end
      end
    end
  end

  // falling edge after the last bit starts the next byte
  always_ff @(posedge clk) begin
    if (rst || !active) begin
      tx_sr <= '0;
    end else if (sck_fall) begin
      if (bit_cnt == 3'd0) begin
        tx_sr <= tx_byte;
      end else begin
        tx_sr <= {tx_sr[6:0], 1'b0};
      end
    end
  end

  assign miso = tx_sr[7];

endmodule

/* common/mcu_pkg.sv */
`include "mcu_params.svh"

package mcu_pkg;

  // decoded command group, held for a whole transfer
  typedef enum logic [3:0] {
    OP_SETADDR,
    OP_ROMMASK,
    OP_SRMASK,
    OP_READ,
    OP_WRITE,
    OP_FEAT,
    OP_MAGIC,
    OP_FREQ,
    OP_ECHO,
    OP_NONE
  } mcu_op_e;

  // bit 3 of a read/write command
  typedef enum logic {
    REG_ROM,
    REG_SRAM
  } mem_region_e;

  ////////////////////////////////////////
  // one event per completed spi byte
  typedef struct packed {
    logic        cmd_ready;
    logic        param_ready;
    logic [7:0]  data;
    logic [31:0] byte_cnt;
  } spi_byte_t;

  typedef struct packed {
    logic                   valid;
    logic                   write;
    mem_region_e            region;
    logic [`MCU_ADDR_W-1:0] addr;
    logic [7:0]             data;
  } mem_req_t;

  // reads only
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } mem_rsp_t;

endpackage

/* common/mcu_params.svh */
`ifndef MCU_PARAMS_SVH
`define MCU_PARAMS_SVH

////////////////////////////////////////
// address and memory sizes
////////////////////////////////////////

// MCU side address width
`define MCU_ADDR_W 24

// byte array index, region bit on top
`define MEM_IDX_W 10

// request credits, same as queue depth
`define MEM_CREDITS 2

////////////////////////////////////////
// frequency measurement
////////////////////////////////////////

`define FREQ_WIN 2000
`define FREQ_W 32

`endif
